// File: decoder.sv
`default_nettype none

module decoder (
  input  logic [rv_pkg::XLEN-1:0]          inst_data_i,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rs1_idx_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rs2_idx_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rd_idx_o,
  output logic [rv_pkg::XLEN-1:0]          imm_o,
  output rv_pkg::alu_op_e                  alu_op_o,
  output rv_pkg::pc_op_e                   pc_op_o,
  output rv_pkg::exc_op_e                  exc_op_o,
  output rv_pkg::src2_sel_e                src2_sel_o,
  output logic                             rd_wen_o
);

  logic [6:0]              funct7;
  logic [2:0]              funct3;
  logic [rv_pkg::XLEN-1:0] imm_i_type;
  logic [rv_pkg::XLEN-1:0] imm_s_type;
  logic [rv_pkg::XLEN-1:0] imm_b_type;
  logic [rv_pkg::XLEN-1:0] imm_u_type;
  logic [rv_pkg::XLEN-1:0] imm_j_type;
  logic                    rd_wen;

  assign funct7 = inst_data_i[31:25];
  assign funct3 = inst_data_i[14:12];

  // register fields sit at fixed positions
  assign rs1_idx_o = inst_data_i[19:15];
  assign rs2_idx_o = inst_data_i[24:20];
  assign rd_idx_o  = inst_data_i[11:7];

  // immediate formats, all sign extended from bit 31
  assign imm_i_type = {{20{inst_data_i[31]}}, inst_data_i[31:20]};
  assign imm_s_type = {{20{inst_data_i[31]}}, inst_data_i[31:25], inst_data_i[11:7]};
  assign imm_b_type = {{19{inst_data_i[31]}}, inst_data_i[31], inst_data_i[7],
                       inst_data_i[30:25], inst_data_i[11:8], 1'b0};
  assign imm_u_type = {inst_data_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_data_i[31]}}, inst_data_i[31], inst_data_i[19:12],
                       inst_data_i[20], inst_data_i[30:21], 1'b0};

  always_comb begin
    imm_o      = imm_i_type;
    alu_op_o   = rv_pkg::alu_none;
    pc_op_o    = rv_pkg::pc_none;
    exc_op_o   = rv_pkg::exc_none;
    src2_sel_o = rv_pkg::src2_rs2;
    rd_wen     = 1'b0;
    case (rv_pkg::opcode_e'(inst_data_i[6:0]))
      rv_pkg::opc_op: begin
        rd_wen = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op_o = rv_pkg::alu_add;
          {7'b0100000, 3'b000}: alu_op_o = rv_pkg::alu_sub;
          {7'b0000000, 3'b001}: alu_op_o = rv_pkg::alu_sll;
          {7'b0000000, 3'b010}: alu_op_o = rv_pkg::alu_slt;
          {7'b0000000, 3'b011}: alu_op_o = rv_pkg::alu_sltu;
          {7'b0000000, 3'b100}: alu_op_o = rv_pkg::alu_xor;
          {7'b0000000, 3'b101}: alu_op_o = rv_pkg::alu_srl;
          {7'b0100000, 3'b101}: alu_op_o = rv_pkg::alu_sra;
          {7'b0000000, 3'b110}: alu_op_o = rv_pkg::alu_or;
          {7'b0000000, 3'b111}: alu_op_o = rv_pkg::alu_and;
          default:              exc_op_o = rv_pkg::exc_illegal;
        endcase
      end
      rv_pkg::opc_op_imm: begin
        rd_wen     = 1'b1;
        src2_sel_o = rv_pkg::src2_imm;
        case (funct3)
          3'b000: alu_op_o = rv_pkg::alu_add;
          3'b010: alu_op_o = rv_pkg::alu_slt;
          3'b011: alu_op_o = rv_pkg::alu_sltu;
          3'b100: alu_op_o = rv_pkg::alu_xor;
          3'b110: alu_op_o = rv_pkg::alu_or;
          3'b111: alu_op_o = rv_pkg::alu_and;
          // shamt lives in imm[4:0], upper bits select the shift kind
          3'b001: begin
            if (funct7 == 7'b0000000) alu_op_o = rv_pkg::alu_sll;
            else                      exc_op_o = rv_pkg::exc_illegal;
          end
          default: begin
            if (funct7 == 7'b0000000)      alu_op_o = rv_pkg::alu_srl;
            else if (funct7 == 7'b0100000) alu_op_o = rv_pkg::alu_sra;
            else                           exc_op_o = rv_pkg::exc_illegal;
          end
        endcase
      end
      rv_pkg::opc_lui: begin
        rd_wen   = 1'b1;
        imm_o    = imm_u_type;
        alu_op_o = rv_pkg::alu_pass_imm;
      end
      rv_pkg::opc_auipc: begin
        rd_wen   = 1'b1;
        imm_o    = imm_u_type;
        alu_op_o = rv_pkg::alu_add_pc;
      end
      rv_pkg::opc_jal: begin
        rd_wen   = 1'b1;
        imm_o    = imm_j_type;
        alu_op_o = rv_pkg::alu_link;
        pc_op_o  = rv_pkg::pc_jal;
      end
      rv_pkg::opc_jalr: begin
        rd_wen   = 1'b1;
        alu_op_o = rv_pkg::alu_link;
        pc_op_o  = rv_pkg::pc_jalr;
        if (funct3 != 3'b000) exc_op_o = rv_pkg::exc_illegal;
      end
      rv_pkg::opc_branch: begin
        imm_o = imm_b_type;
        case (funct3)
          3'b000:  pc_op_o  = rv_pkg::pc_beq;
          3'b001:  pc_op_o  = rv_pkg::pc_bne;
          3'b100:  pc_op_o  = rv_pkg::pc_blt;
          3'b101:  pc_op_o  = rv_pkg::pc_bge;
          3'b110:  pc_op_o  = rv_pkg::pc_bltu;
          3'b111:  pc_op_o  = rv_pkg::pc_bgeu;
          default: exc_op_o = rv_pkg::exc_illegal;
        endcase
      end
      // only the exact ecall and ebreak words, csr ops are not here
      rv_pkg::opc_system: begin
        if (inst_data_i == 32'h0000_0073)      exc_op_o = rv_pkg::exc_ecall;
        else if (inst_data_i == 32'h0010_0073) exc_op_o = rv_pkg::exc_ebreak;
        else                                   exc_op_o = rv_pkg::exc_illegal;
      end
      // no data memory
      rv_pkg::opc_store: begin
        imm_o    = imm_s_type;
        exc_op_o = rv_pkg::exc_illegal;
      end
      default: exc_op_o = rv_pkg::exc_illegal;
    endcase
    // a trapping instruction does nothing else
    if (exc_op_o != rv_pkg::exc_none) begin
      alu_op_o = rv_pkg::alu_none;
      pc_op_o  = rv_pkg::pc_none;
      rd_wen   = 1'b0;
    end
  end

  // writes to x0 dropped here already
  assign rd_wen_o = rd_wen & (rd_idx_o != '0);

endmodule

`default_nettype wire

// File: ex_stage.sv
`default_nettype none

module ex_stage #(
  parameter logic [rv_pkg::XLEN-1:0] TRAP_VECTOR = '0
) (
  input  logic                             stall_i,
  input  logic                             valid_i,
  input  logic [rv_pkg::XLEN-1:0]          inst_addr_i,
  input  logic                             bpu_taken_i,
  input  logic [rv_pkg::XLEN-1:0]          imm_i,
  input  logic [rv_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]          rs2_data_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rd_idx_i,
  input  rv_pkg::alu_op_e                  alu_op_i,
  input  rv_pkg::pc_op_e                   pc_op_i,
  input  rv_pkg::exc_op_e                  exc_op_i,
  input  rv_pkg::src2_sel_e                src2_sel_i,
  input  logic                             rd_wen_i,
  output logic                             wb_wen_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] wb_idx_o,
  output logic [rv_pkg::XLEN-1:0]          wb_data_o,
  output logic                             redirect_o,
  output logic [rv_pkg::XLEN-1:0]          redirect_addr_o,
  output logic                             trap_o,
  output logic [rv_pkg::XLEN-1:0]          trap_pc_o,
  output rv_pkg::exc_op_e                  trap_cause_o
);

  logic [rv_pkg::XLEN-1:0] op2;
  logic [rv_pkg::XLEN-1:0] alu_res;
  logic [rv_pkg::XLEN-1:0] seq_pc;
  logic [rv_pkg::XLEN-1:0] target;
  logic                    taken;
  logic                    fire;
  logic                    is_trap;

  assign op2    = (src2_sel_i == rv_pkg::src2_imm) ? imm_i : rs2_data_i;
  assign seq_pc = inst_addr_i + 32'd4;

  always_comb begin
    case (alu_op_i)
      rv_pkg::alu_add:      alu_res = rs1_data_i + op2;
      rv_pkg::alu_sub:      alu_res = rs1_data_i - op2;
      rv_pkg::alu_and:      alu_res = rs1_data_i & op2;
      rv_pkg::alu_or:       alu_res = rs1_data_i | op2;
      rv_pkg::alu_xor:      alu_res = rs1_data_i ^ op2;
      // shift amount is op2[4:0] only
      rv_pkg::alu_sll:      alu_res = rs1_data_i << op2[4:0];
      rv_pkg::alu_srl:      alu_res = rs1_data_i >> op2[4:0];
      rv_pkg::alu_sra:      alu_res = $signed(rs1_data_i) >>> op2[4:0];
      rv_pkg::alu_slt:      alu_res = {31'b0, $signed(rs1_data_i) < $signed(op2)};
      rv_pkg::alu_sltu:     alu_res = {31'b0, rs1_data_i < op2};
      rv_pkg::alu_pass_imm: alu_res = imm_i;
      rv_pkg::alu_add_pc:   alu_res = inst_addr_i + imm_i;
      rv_pkg::alu_link:     alu_res = seq_pc;
      default:              alu_res = '0;
    endcase
  end

  // actual direction, non-branches never taken
  always_comb begin
    case (pc_op_i)
      rv_pkg::pc_jal:  taken = 1'b1;
      rv_pkg::pc_jalr: taken = 1'b1;
      rv_pkg::pc_beq:  taken = rs1_data_i == rs2_data_i;
      rv_pkg::pc_bne:  taken = rs1_data_i != rs2_data_i;
      rv_pkg::pc_blt:  taken = $signed(rs1_data_i) < $signed(rs2_data_i);
      rv_pkg::pc_bge:  taken = $signed(rs1_data_i) >= $signed(rs2_data_i);
      rv_pkg::pc_bltu: taken = rs1_data_i < rs2_data_i;
      rv_pkg::pc_bgeu: taken = rs1_data_i >= rs2_data_i;
      default:         taken = 1'b0;
    endcase
  end

  // jalr target has bit 0 cleared
  assign target = (pc_op_i == rv_pkg::pc_jalr) ? ((rs1_data_i + imm_i) & ~32'd1)
                                               : (inst_addr_i + imm_i);

  // nothing leaves execute while stalled or on a bubble
  assign fire    = valid_i & ~stall_i;
  assign is_trap = exc_op_i != rv_pkg::exc_none;

  assign wb_wen_o  = fire & rd_wen_i & ~is_trap;
  assign wb_idx_o  = fire ? rd_idx_i : '0;
  assign wb_data_o = fire ? alu_res : '0;

  // trap redirect wins over the prediction check
  assign redirect_o = fire & (is_trap | (taken != bpu_taken_i));
  always_comb begin
    if (!fire)      redirect_addr_o = '0;
    else if (is_trap) redirect_addr_o = TRAP_VECTOR;
    else if (taken) redirect_addr_o = target;
    else            redirect_addr_o = seq_pc;
  end

  assign trap_o       = fire & is_trap;
  assign trap_pc_o    = trap_o ? inst_addr_i : '0;
  assign trap_cause_o = trap_o ? exc_op_i : rv_pkg::exc_none;

endmodule

`default_nettype wire

// File: flist.f
rv_pkg.sv
decoder.sv
regfile.sv
id_ex.sv
ex_stage.sv
id_ex_core.sv
tb_id_ex_core.sv

// File: id_ex.sv
`default_nettype none

module id_ex #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             stall_i,
  input  logic                             flush_i,
  input  logic                             valid_i,
  input  logic [rv_pkg::XLEN-1:0]          inst_addr_i,
  input  logic                             bpu_taken_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rs1_idx_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rs2_idx_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rd_idx_i,
  input  logic [rv_pkg::XLEN-1:0]          imm_i,
  input  logic [rv_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]          rs2_data_i,
  input  rv_pkg::alu_op_e                  alu_op_i,
  input  rv_pkg::pc_op_e                   pc_op_i,
  input  rv_pkg::exc_op_e                  exc_op_i,
  input  rv_pkg::src2_sel_e                src2_sel_i,
  input  logic                             rd_wen_i,
  output logic                             valid_o,
  output logic [rv_pkg::XLEN-1:0]          inst_addr_o,
  output logic                             bpu_taken_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rs1_idx_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rs2_idx_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] rd_idx_o,
  output logic [rv_pkg::XLEN-1:0]          imm_o,
  output logic [rv_pkg::XLEN-1:0]          rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]          rs2_data_o,
  output rv_pkg::alu_op_e                  alu_op_o,
  output rv_pkg::pc_op_e                   pc_op_o,
  output rv_pkg::exc_op_e                  exc_op_o,
  output rv_pkg::src2_sel_e                src2_sel_o,
  output logic                             rd_wen_o
);

  logic load_en;
  logic load_bubble;

  // reset always lands, flush only on an edge that is not stalled
  assign load_en     = rst_i | ~stall_i;
  assign load_bubble = rst_i | flush_i;

  always_ff @(posedge clk) begin
    if (load_en) begin
      if (load_bubble) begin
        // bubble keeps the nop fields but carries no operation
        valid_o     <= 1'b0;
        inst_addr_o <= RESET_PC;
        bpu_taken_o <= 1'b0;
        rs1_idx_o   <= rv_pkg::INST_NOP[19:15];
        rs2_idx_o   <= rv_pkg::INST_NOP[24:20];
        rd_idx_o    <= rv_pkg::INST_NOP[11:7];
        imm_o       <= {{(rv_pkg::XLEN-12){rv_pkg::INST_NOP[31]}}, rv_pkg::INST_NOP[31:20]};
        rs1_data_o  <= '0;
        rs2_data_o  <= '0;
        alu_op_o    <= rv_pkg::alu_none;
        pc_op_o     <= rv_pkg::pc_none;
        exc_op_o    <= rv_pkg::exc_none;
        src2_sel_o  <= rv_pkg::src2_imm;
        rd_wen_o    <= 1'b0;
      end else begin
        valid_o     <= valid_i;
        inst_addr_o <= inst_addr_i;
        bpu_taken_o <= bpu_taken_i;
        rs1_idx_o   <= rs1_idx_i;
        rs2_idx_o   <= rs2_idx_i;
        rd_idx_o    <= rd_idx_i;
        imm_o       <= imm_i;
        rs1_data_o  <= rs1_data_i;
        rs2_data_o  <= rs2_data_i;
        alu_op_o    <= alu_op_i;
        pc_op_o     <= pc_op_i;
        exc_op_o    <= exc_op_i;
        src2_sel_o  <= src2_sel_i;
        rd_wen_o    <= rd_wen_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: id_ex_core.sv
`default_nettype none

module id_ex_core #(
  parameter logic [rv_pkg::XLEN-1:0] TRAP_VECTOR = 32'h8000_0100,
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC    = 32'h8000_0000
) (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic                             stall_i,
  input  logic                             inst_valid_i,
  input  logic [rv_pkg::XLEN-1:0]          inst_addr_i,
  input  logic [rv_pkg::XLEN-1:0]          inst_data_i,
  input  logic                             bpu_taken_i,
  output logic                             wb_wen_o,
  output logic [rv_pkg::REG_ADDRWIDTH-1:0] wb_idx_o,
  output logic [rv_pkg::XLEN-1:0]          wb_data_o,
  output logic                             redirect_o,
  output logic [rv_pkg::XLEN-1:0]          redirect_addr_o,
  output logic                             trap_o,
  output logic [rv_pkg::XLEN-1:0]          trap_pc_o,
  output rv_pkg::exc_op_e                  trap_cause_o
);

  // decode side
  logic [rv_pkg::REG_ADDRWIDTH-1:0] dec_rs1_idx;
  logic [rv_pkg::REG_ADDRWIDTH-1:0] dec_rs2_idx;
  logic [rv_pkg::REG_ADDRWIDTH-1:0] dec_rd_idx;
  logic [rv_pkg::XLEN-1:0]          dec_imm;
  rv_pkg::alu_op_e                  dec_alu_op;
  rv_pkg::pc_op_e                   dec_pc_op;
  rv_pkg::exc_op_e                  dec_exc_op;
  rv_pkg::src2_sel_e                dec_src2_sel;
  logic                             dec_rd_wen;
  logic [rv_pkg::XLEN-1:0]          rf_rs1_data;
  logic [rv_pkg::XLEN-1:0]          rf_rs2_data;

  // execute side, out of the pipeline register
  logic                             ex_valid;
  logic [rv_pkg::XLEN-1:0]          ex_inst_addr;
  logic                             ex_bpu_taken;
  logic [rv_pkg::REG_ADDRWIDTH-1:0] ex_rd_idx;
  logic [rv_pkg::XLEN-1:0]          ex_imm;
  logic [rv_pkg::XLEN-1:0]          ex_rs1_data;
  logic [rv_pkg::XLEN-1:0]          ex_rs2_data;
  rv_pkg::alu_op_e                  ex_alu_op;
  rv_pkg::pc_op_e                   ex_pc_op;
  rv_pkg::exc_op_e                  ex_exc_op;
  rv_pkg::src2_sel_e                ex_src2_sel;
  logic                             ex_rd_wen;

  decoder u_decoder (
    .inst_data_i (inst_data_i),
    .rs1_idx_o   (dec_rs1_idx),
    .rs2_idx_o   (dec_rs2_idx),
    .rd_idx_o    (dec_rd_idx),
    .imm_o       (dec_imm),
    .alu_op_o    (dec_alu_op),
    .pc_op_o     (dec_pc_op),
    .exc_op_o    (dec_exc_op),
    .src2_sel_o  (dec_src2_sel),
    .rd_wen_o    (dec_rd_wen)
  );

  // write port fed straight from execute
  regfile u_regfile (
    .clk        (clk),
    .rst_i      (rst_i),
    .rs1_idx_i  (dec_rs1_idx),
    .rs2_idx_i  (dec_rs2_idx),
    .wen_i      (wb_wen_o),
    .wd_idx_i   (wb_idx_o),
    .wd_data_i  (wb_data_o),
    .rs1_data_o (rf_rs1_data),
    .rs2_data_o (rf_rs2_data)
  );

  // redirect doubles as flush for the instruction behind it
  id_ex #(
    .RESET_PC (RESET_PC)
  ) u_id_ex (
    .clk         (clk),
    .rst_i       (rst_i),
    .stall_i     (stall_i),
    .flush_i     (redirect_o),
    .valid_i     (inst_valid_i),
    .inst_addr_i (inst_addr_i),
    .bpu_taken_i (bpu_taken_i),
    .rs1_idx_i   (dec_rs1_idx),
    .rs2_idx_i   (dec_rs2_idx),
    .rd_idx_i    (dec_rd_idx),
    .imm_i       (dec_imm),
    .rs1_data_i  (rf_rs1_data),
    .rs2_data_i  (rf_rs2_data),
    .alu_op_i    (dec_alu_op),
    .pc_op_i     (dec_pc_op),
    .exc_op_i    (dec_exc_op),
    .src2_sel_i  (dec_src2_sel),
    .rd_wen_i    (dec_rd_wen),
    .valid_o     (ex_valid),
    .inst_addr_o (ex_inst_addr),
    .bpu_taken_o (ex_bpu_taken),
    // source indices have no consumer past this register
    .rs1_idx_o   (),
    .rs2_idx_o   (),
    .rd_idx_o    (ex_rd_idx),
    .imm_o       (ex_imm),
    .rs1_data_o  (ex_rs1_data),
    .rs2_data_o  (ex_rs2_data),
    .alu_op_o    (ex_alu_op),
    .pc_op_o     (ex_pc_op),
    .exc_op_o    (ex_exc_op),
    .src2_sel_o  (ex_src2_sel),
    .rd_wen_o    (ex_rd_wen)
  );

  ex_stage #(
    .TRAP_VECTOR (TRAP_VECTOR)
  ) u_ex_stage (
    .stall_i         (stall_i),
    .valid_i         (ex_valid),
    .inst_addr_i     (ex_inst_addr),
    .bpu_taken_i     (ex_bpu_taken),
    .imm_i           (ex_imm),
    .rs1_data_i      (ex_rs1_data),
    .rs2_data_i      (ex_rs2_data),
    .rd_idx_i        (ex_rd_idx),
    .alu_op_i        (ex_alu_op),
    .pc_op_i         (ex_pc_op),
    .exc_op_i        (ex_exc_op),
    .src2_sel_i      (ex_src2_sel),
    .rd_wen_i        (ex_rd_wen),
    .wb_wen_o        (wb_wen_o),
    .wb_idx_o        (wb_idx_o),
    .wb_data_o       (wb_data_o),
    .redirect_o      (redirect_o),
    .redirect_addr_o (redirect_addr_o),
    .trap_o          (trap_o),
    .trap_pc_o       (trap_pc_o),
    .trap_cause_o    (trap_cause_o)
  );

endmodule

`default_nettype wire

// File: regfile.sv
`default_nettype none

module regfile (
  input  logic                             clk,
  input  logic                             rst_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rs1_idx_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] rs2_idx_i,
  input  logic                             wen_i,
  input  logic [rv_pkg::REG_ADDRWIDTH-1:0] wd_idx_i,
  input  logic [rv_pkg::XLEN-1:0]          wd_data_i,
  output logic [rv_pkg::XLEN-1:0]          rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]          rs2_data_o
);

  logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDRWIDTH];

  // one read port, x0 first, then same-cycle write-back bypass
  function automatic logic [rv_pkg::XLEN-1:0] read_port(
    input logic [rv_pkg::REG_ADDRWIDTH-1:0] idx
  );
    if (idx == '0) return '0;
    if (wen_i && (wd_idx_i == idx)) return wd_data_i;
    return regs[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < 2**rv_pkg::REG_ADDRWIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && (wd_idx_i != '0)) begin
      regs[wd_idx_i] <= wd_data_i;
    end
  end

  always_comb rs1_data_o = read_port(rs1_idx_i);
  always_comb rs2_data_o = read_port(rs2_idx_i);

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_id_ex_core -f flist.f -o sim_tb

# simulation status is judged from the log
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
grep -q "All tests passed!" sim.log

// File: rv_pkg.sv
`default_nettype none

package rv_pkg;

  // datapath, address and register index widths
  parameter int XLEN = 32;
  parameter int REG_ADDRWIDTH = 5;

  // addi x0, x0, 0, the word a bubble stands for
  parameter logic [XLEN-1:0] INST_NOP = 32'h0000_0013;

  // major opcodes seen by the decoder
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_store  = 7'b0100011,
    opc_system = 7'b1110011
  } opcode_e;

  // alu operation
  typedef enum logic [3:0] {
    alu_none,
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_imm,
    alu_add_pc,
    alu_link
  } alu_op_e;

  // control flow kind
  typedef enum logic [3:0] {
    pc_none,
    pc_jal,
    pc_jalr,
    pc_beq,
    pc_bne,
    pc_blt,
    pc_bge,
    pc_bltu,
    pc_bgeu
  } pc_op_e;

  // exception kind, also reported as trap cause
  typedef enum logic [1:0] {
    exc_none,
    exc_ecall,
    exc_ebreak,
    exc_illegal
  } exc_op_e;

  // second alu operand
  typedef enum logic {
    src2_rs2,
    src2_imm
  } src2_sel_e;

endpackage

`default_nettype wire

// File: tb_id_ex_core.sv
`default_nettype none

module tb_id_ex_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] TRAP_VECTOR = 32'h8000_0100;
  localparam logic [31:0] RESET_PC    = 32'h8000_0000;
  localparam int NUM_INST   = 2000;
  localparam int RESET_AT   = 1000;
  localparam int MAX_CYCLES = 4 * NUM_INST;

  // expected execute-stage outputs of one instruction
  typedef struct packed {
    logic        wen;
    logic [4:0]  idx;
    logic [31:0] data;
    logic        redir;
    logic [31:0] raddr;
    logic        trap;
    logic [31:0] tpc;
    logic [1:0]  cause;
  } result_t;

  logic clk = 1'b0;
  logic rst_i, stall_i, inst_valid_i, bpu_taken_i;
  logic [31:0] inst_addr_i, inst_data_i;
  logic wb_wen_o, redirect_o, trap_o;
  logic [4:0] wb_idx_o;
  logic [31:0] wb_data_o, redirect_addr_o, trap_pc_o;
  rv_pkg::exc_op_e trap_cause_o;

  logic [15:0] lfsr = 16'd64071;
  logic [31:0] xreg [32];
  result_t     exp_q [$];
  int          cycles = 0;

  id_ex_core #(.TRAP_VECTOR(TRAP_VECTOR), .RESET_PC(RESET_PC)) dut0 (
    .clk(clk), .rst_i(rst_i), .stall_i(stall_i), .inst_valid_i(inst_valid_i),
    .inst_addr_i(inst_addr_i), .inst_data_i(inst_data_i), .bpu_taken_i(bpu_taken_i),
    .wb_wen_o(wb_wen_o), .wb_idx_o(wb_idx_o), .wb_data_o(wb_data_o),
    .redirect_o(redirect_o), .redirect_addr_o(redirect_addr_o),
    .trap_o(trap_o), .trap_pc_o(trap_pc_o), .trap_cause_o(trap_cause_o)
  );

  always #50 clk = ~clk;

  // runaway guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout after %0d cycles, not all instructions retired", cycles);
      $display("Test failures found");
      $fatal(1);
    end
  end

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s expected %h actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // register fields kept to x0..x7 so dependences are frequent
  function automatic logic [31:0] gen_inst();
    logic [3:0] kind;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    kind  = 4'(rand_bits(4));
    rd    = 5'(rand_bits(3));
    rs1   = 5'(rand_bits(3));
    rs2   = 5'(rand_bits(3));
    f3    = 3'(rand_bits(3));
    f7    = rand_bits(1) ? 7'h20 : 7'h00;
    imm12 = 12'(rand_bits(12));
    imm20 = 20'(rand_bits(20));
    case (kind)
      4'd0, 4'd1, 4'd14: return {f7, rs2, rs1, f3, rd, 7'b0110011};
      4'd2, 4'd3: begin
        if (f3 == 3'd1 || f3 == 3'd5) return {f7, imm12[4:0], rs1, f3, rd, 7'b0010011};
        return {imm12, rs1, f3, rd, 7'b0010011};
      end
      4'd4:       return {imm20, rd, 7'b0110111};
      4'd5:       return {imm20, rd, 7'b0010111};
      4'd6:       return {imm20, rd, 7'b1101111};
      4'd7:       return {imm12, rs1, 3'b000, rd, 7'b1100111};
      4'd8, 4'd9: return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
      4'd10:      return 32'h0000_0073;
      4'd11:      return 32'h0010_0073;
      4'd12:      return {imm12, rs1, f3, rd, 7'b0000011};
      4'd13:      return rand_bits(32);
      default:    return {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
    endcase
  endfunction

  // alu per rv32i funct3 where alt selects sub or sra
  function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // isa reference model reading the model registers at acceptance
  function automatic result_t model_exec(input logic [31:0] w, input logic [31:0] pc,
                                         input logic pred);
    result_t r;
    logic [31:0] a, b, imm_i, imm_b, imm_j, imm_u, tgt;
    logic [2:0] f3;
    logic [6:0] f7;
    logic tk, wr;
    logic [1:0] cause;
    a = xreg[w[19:15]];
    b = xreg[w[24:20]];
    f3 = w[14:12];
    f7 = w[31:25];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    imm_u = {w[31:12], 12'b0};
    r = '0;
    tk = 1'b0;
    wr = 1'b0;
    tgt = '0;
    cause = 2'd0;
    case (w[6:0])
      7'b0110011: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
          wr = 1'b1;
          r.data = alu(f3, f7[5], a, b);
        end else cause = 2'd3;
      end
      7'b0010011: begin
        if ((f3 == 3'd1 && f7 != 7'h00) || (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20))
          cause = 2'd3;
        else begin
          wr = 1'b1;
          r.data = alu(f3, f3 == 3'd5 && f7[5], a, imm_i);
        end
      end
      7'b0110111: begin
        wr = 1'b1;
        r.data = imm_u;
      end
      7'b0010111: begin
        wr = 1'b1;
        r.data = pc + imm_u;
      end
      7'b1101111: begin
        wr = 1'b1;
        r.data = pc + 4;
        tk = 1'b1;
        tgt = pc + imm_j;
      end
      7'b1100111: begin
        if (f3 != 3'd0) cause = 2'd3;
        else begin
          wr = 1'b1;
          r.data = pc + 4;
          tk = 1'b1;
          tgt = (a + imm_i) & 32'hFFFF_FFFE;
        end
      end
      7'b1100011: begin
        tgt = pc + imm_b;
        case (f3)
          3'd0:    tk = a == b;
          3'd1:    tk = a != b;
          3'd4:    tk = $signed(a) < $signed(b);
          3'd5:    tk = $signed(a) >= $signed(b);
          3'd6:    tk = a < b;
          3'd7:    tk = a >= b;
          default: cause = 2'd3;
        endcase
      end
      7'b1110011: cause = (w == 32'h73) ? 2'd1 : (w == 32'h0010_0073) ? 2'd2 : 2'd3;
      default:    cause = 2'd3;
    endcase
    if (cause != 2'd0) begin
      r = '0;
      r.trap = 1'b1;
      r.tpc = pc;
      r.cause = cause;
      r.redir = 1'b1;
      r.raddr = TRAP_VECTOR;
    end else begin
      r.wen = wr && (w[11:7] != 5'd0);
      r.idx = w[11:7];
      r.redir = tk != pred;
      r.raddr = tk ? tgt : pc + 4;
    end
    return r;
  endfunction

  task automatic check_outputs(input result_t e, input logic active);
    check("wb_wen", 32'(active & e.wen), 32'(wb_wen_o));
    check("redirect", 32'(active & e.redir), 32'(redirect_o));
    check("trap", 32'(active & e.trap), 32'(trap_o));
    if (active && e.wen) begin
      check("wb_idx", 32'(e.idx), 32'(wb_idx_o));
      check("wb_data", e.data, wb_data_o);
    end
    if (active && e.redir) check("redirect_addr", e.raddr, redirect_addr_o);
    if (active && e.trap) begin
      check("trap_pc", e.tpc, trap_pc_o);
      check("trap_cause", 32'(e.cause), 32'(trap_cause_o));
    end
  endtask

  // 5 reset cycles with quiet outputs after the first edge
  task automatic apply_reset();
    rst_i = 1'b1;
    stall_i = 1'b0;
    inst_valid_i = 1'b0;
    for (int i = 0; i < 5; i++) begin
      @(posedge clk);
      #1;
      check_outputs('0, 1'b0);
    end
    rst_i = 1'b0;
    for (int i = 0; i < 32; i++) xreg[i] = '0;
    exp_q.delete();
  endtask

  initial begin
    logic [31:0] fetch_pc;
    logic need_new, force_addi;
    result_t e;
    int accepted;
    rst_i = 1'b1;
    stall_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_addr_i = '0;
    inst_data_i = '0;
    bpu_taken_i = 1'b0;
    apply_reset();
    fetch_pc = RESET_PC;
    need_new = 1'b1;
    force_addi = 1'b0;
    accepted = 0;
    while (accepted < NUM_INST) begin
      if (accepted == RESET_AT && force_addi == 1'b0) begin
        // reset is raised just after a rising edge like any other input
        @(posedge clk);
        #1;
        apply_reset();
        fetch_pc = RESET_PC;
        need_new = 1'b1;
        force_addi = 1'b1;
      end else begin
        @(posedge clk);
        #1;
      end
      if (need_new) begin
        inst_valid_i = force_addi || (rand_bits(3) != 0);
        inst_addr_i = fetch_pc;
        bpu_taken_i = rand_bits(1);
        // addi from a cleared register must yield its immediate
        if (force_addi) inst_data_i = {12'(rand_bits(12)), 5'(rand_bits(3)), 3'b000,
                                       5'(rand_bits(3)) + 5'd1, 7'b0010011};
        else inst_data_i = gen_inst();
      end
      stall_i = (rand_bits(3) == 0);
      e = (exp_q.size() != 0) ? exp_q[0] : '0;
      @(negedge clk);
      check_outputs(e, !stall_i && exp_q.size() != 0);
      if (stall_i) begin
        need_new = 1'b0;
      end else begin
        need_new = 1'b1;
        if (exp_q.size() != 0) begin
          void'(exp_q.pop_front());
          if (e.wen) xreg[e.idx] = e.data;
        end
        // any redirect drops the word presented behind it
        if (e.redir) begin
          fetch_pc = e.raddr;
        end else if (inst_valid_i) begin
          exp_q.push_back(model_exec(inst_data_i, inst_addr_i, bpu_taken_i));
          fetch_pc = fetch_pc + 4;
          accepted++;
          if (force_addi) force_addi = 1'b0;
        end
      end
    end
    // let the last instruction retire
    @(posedge clk);
    #1;
    stall_i = 1'b0;
    inst_valid_i = 1'b0;
    e = (exp_q.size() != 0) ? exp_q[0] : '0;
    @(negedge clk);
    check_outputs(e, exp_q.size() != 0);
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
